/* prbs_config.svh */
// --------------------------------------
// PRBS link test build configuration
// Word width, LFSR taps, seed and link credits
// --------------------------------------
`ifndef PRBS_CONFIG_SVH
`define PRBS_CONFIG_SVH

// Bits per PRBS word and width of both LFSRs
`define PRBS_WIDTH 16

// Maximal-length taps for x^16 + x^14 + x^13 + x^11 + 1 with the MSB set
`define PRBS_TAPS 16'hB400

// Generator seed loaded on every start and never zero
`define PRBS_SEED 16'hACE1

// Depth of the receive queue, which is also the credit count after reset
`define LINK_CREDITS 4

// Width of the statistic counters
`define CNT_WIDTH 32

`endif

/* prbs_pkg.sv */
// --------------------------------------
// PRBS link test types
// Shared by the generator, the checker and the link
// --------------------------------------
`include "prbs_config.svh"

package prbs_pkg;

  // One PRBS word, which is also one LFSR state
  typedef logic [`PRBS_WIDTH-1:0] prbs_word_t;

  // Credit count that can hold every value from zero up to LINK_CREDITS
  typedef logic [$clog2(`LINK_CREDITS + 1)-1:0] credit_t;

  // Statistic counter for words sent, words checked and errors
  typedef logic [`CNT_WIDTH-1:0] stat_cnt_t;

  // One entry of the receive queue
  // The sof flag marks the first word after a start
  typedef struct packed {
    logic       sof;
    prbs_word_t data;
  } link_entry_t;

endpackage

/* prbs_link_if.sv */
// --------------------------------------
// Generator to checker link
// Valid/sof/data forward and one-cycle credit return
// --------------------------------------
`timescale 1ns/1ps

interface prbs_link_if import prbs_pkg::*; ();

  // A word is on the link in every cycle where valid is high
  logic       valid;
  // First word of a run, which the checker locks onto
  logic       sof;
  // Payload word
  prbs_word_t data;
  // One-cycle pulse that returns one credit to the sender
  logic       credit;

  // The generator launches words and takes credits back
  modport sender (
    output valid,
    output sof,
    output data,
    input  credit
  );

  // The checker accepts words and returns credits
  modport receiver (
    input  valid,
    input  sof,
    input  data,
    output credit
  );

endinterface

/* lfsr.sv */
// --------------------------------------
// Fibonacci LFSR
// Shifts the masked XOR of its state into the LSB
// --------------------------------------
`timescale 1ns/1ps

module lfsr import prbs_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Loads initial_state and takes priority over advance
  input  logic       reinit,
  // State loaded on reset and on reinit
  input  prbs_word_t initial_state,
  // Feedback mask with the MSB set for a maximal period
  input  prbs_word_t taps,
  // Steps the register by one state
  input  logic       advance,
  // LSB of the state
  output logic       out,
  // Whole state
  output prbs_word_t out_state
);

  prbs_word_t state;
  prbs_word_t next_state;

  // --------------------------------------
  // Next state
  // --------------------------------------

  // The old state moves up one bit and the MSB drops out
  // The XOR reduction of the tapped bits becomes the new LSB
  assign next_state = reinit ? initial_state
                             : {state[$bits(prbs_word_t)-2:0], ^(state & taps)};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= initial_state;
    end else if (reinit || advance) begin
      state <= next_state;
    end
  end

  assign out       = state[0];
  assign out_state = state;

  // --------------------------------------
  // Checks
  // --------------------------------------

  // A zero state is a fixed point, so the sequence would stall there for good
  a_state_non_zero: assert property (@(posedge clk) disable iff (rst)
    out_state != '0)
    else $error("lfsr: state reached zero");

  // With a nonzero state every plain step must move to a new state
  a_advance_changes: assert property (@(posedge clk) disable iff (rst)
    advance && !reinit |=> out_state != $past(out_state))
    else $error("lfsr: advance left the state unchanged");

endmodule

/* prbs_generator.sv */
// --------------------------------------
// PRBS generator
// Launches LFSR words onto the link under credit control
// --------------------------------------
`timescale 1ns/1ps
`include "prbs_config.svh"

module prbs_generator import prbs_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      stop,
  input  logic      inject_error,
  prbs_link_if.sender link,
  output stat_cnt_t sent_count
);

  logic       running;
  logic       sof_pend;
  logic       inject_pend;
  credit_t    credits;
  logic       launch;
  logic       inject_now;
  prbs_word_t lfsr_state;

  // --------------------------------------
  // Word source
  // --------------------------------------

  // The LFSR is loaded with the seed on the same edge that samples start
  // Every launch steps it, so the link carries consecutive states
  lfsr u_lfsr (
    .clk           (clk),
    .rst           (rst),
    .reinit        (start),
    .initial_state (prbs_word_t'(`PRBS_SEED)),
    .taps          (prbs_word_t'(`PRBS_TAPS)),
    .advance       (launch),
    .out           (),
    .out_state     (lfsr_state)
  );

  // One word per cycle while running and holding at least one credit
  assign launch = running && (credits != '0);

  // The sof word is never corrupted because the checker seeds its LFSR from it
  assign inject_now = inject_pend && !sof_pend;

  assign link.valid = launch;
  assign link.sof   = sof_pend;
  assign link.data  = lfsr_state ^ prbs_word_t'(inject_now);

  // --------------------------------------
  // Run control and credits
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      running     <= 1'b0;
      sof_pend    <= 1'b0;
      inject_pend <= 1'b0;
      credits     <= credit_t'(`LINK_CREDITS);
      sent_count  <= '0;
    end else begin
      // Start wins over a stop in the same cycle
      if (start) begin
        running <= 1'b1;
      end else if (stop) begin
        running <= 1'b0;
      end
      // The flag stays up until the first word of the run has gone out
      if (start) begin
        sof_pend <= 1'b1;
      end else if (launch) begin
        sof_pend <= 1'b0;
      end
      // A request waits for the next non-sof launch and is then used up
      if (inject_error) begin
        inject_pend <= 1'b1;
      end else if (launch && inject_now) begin
        inject_pend <= 1'b0;
      end
      // Spend one credit per launch and take back one per returned pulse
      credits <= credits + credit_t'(link.credit) - credit_t'(launch);
      if (launch) begin
        sent_count <= sent_count + stat_cnt_t'(1);
      end
    end
  end

  // --------------------------------------
  // Checks
  // --------------------------------------

  // The checker can never return more credits than were spent
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= credit_t'(`LINK_CREDITS))
    else $error("prbs_generator: credit count above LINK_CREDITS");

endmodule

/* prbs_checker.sv */
// --------------------------------------
// PRBS checker
// Queues link words, locks on sof and counts mismatches
// --------------------------------------
`timescale 1ns/1ps
`include "prbs_config.svh"

module prbs_checker import prbs_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      drain_en,
  prbs_link_if.receiver link,
  output logic      locked,
  output stat_cnt_t words_checked,
  output stat_cnt_t errors
);

  // The queue holds exactly as many entries as the sender has credits
  localparam int depth = `LINK_CREDITS;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  link_entry_t      queue_mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  credit_t          fill;
  link_entry_t      head;
  logic             push;
  logic             pop;
  logic             pop_sof;
  logic             check;
  logic             mismatch;
  logic             priming;
  prbs_word_t       lfsr_init;
  prbs_word_t       expected;

  // Circular pointer step that wraps at the last slot
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // --------------------------------------
  // Receive queue
  // --------------------------------------

  // Every valid cycle is accepted since credit flow keeps the queue from filling up
  assign push = link.valid;
  assign head = queue_mem[rd_ptr];

  // No pop while priming, so the prime step sees a stable LFSR
  assign pop = drain_en && (fill != '0) && !priming;

  always_ff @(posedge clk) begin
    if (push) begin
      queue_mem[wr_ptr] <= '{sof: link.sof, data: link.data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fill        <= '0;
      link.credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      fill        <= fill + credit_t'(push) - credit_t'(pop);
      // Each pop hands one credit back on the following cycle
      link.credit <= pop;
    end
  end

  // --------------------------------------
  // Expected sequence
  // --------------------------------------

  assign pop_sof = pop && head.sof;

  // An sof pop loads the received word
  // Out of reset the register starts from the seed and stays nonzero
  assign lfsr_init = pop_sof ? head.data : prbs_word_t'(`PRBS_SEED);

  // The cycle after an sof pop steps the LFSR once to the next expected word
  // Each later pop steps it past the word just checked
  lfsr u_lfsr (
    .clk           (clk),
    .rst           (rst),
    .reinit        (pop_sof),
    .initial_state (lfsr_init),
    .taps          (prbs_word_t'(`PRBS_TAPS)),
    .advance       (priming || (pop && !head.sof)),
    .out           (),
    .out_state     (expected)
  );

  // Only words that follow a lock are compared
  assign check    = pop && !head.sof && locked;
  assign mismatch = head.data != expected;

  // --------------------------------------
  // Lock state and counters
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      priming       <= 1'b0;
      locked        <= 1'b0;
      words_checked <= '0;
      errors        <= '0;
    end else begin
      priming <= pop_sof;
      // Lock holds until reset
      if (pop_sof) begin
        locked <= 1'b1;
      end
      if (check) begin
        words_checked <= words_checked + stat_cnt_t'(1);
        // The LFSR keeps stepping, so a flipped bit counts once
        if (mismatch) begin
          errors <= errors + stat_cnt_t'(1);
        end
      end
    end
  end

  // --------------------------------------
  // Checks
  // --------------------------------------

  // The sender's credit count must keep pushes away from a full queue
  a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
    push |-> (fill != credit_t'(depth)) || pop)
    else $error("prbs_checker: push into a full receive queue");

endmodule

/* prbs_top.sv */
// --------------------------------------
// PRBS link test top level
// Generator and checker joined by the credit link
// --------------------------------------
`timescale 1ns/1ps

module prbs_top import prbs_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // Run control for the generator
  input  logic      start,
  input  logic      stop,
  // One corrupted word per pulse
  input  logic      inject_error,
  // Low to hold the receive queue and back-pressure the generator
  input  logic      drain_en,
  output stat_cnt_t sent_count,
  output stat_cnt_t words_checked,
  output stat_cnt_t errors,
  output logic      locked
);

  // Internal link between the two halves
  prbs_link_if link ();

  prbs_generator u_generator (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .stop         (stop),
    .inject_error (inject_error),
    .link         (link.sender),
    .sent_count   (sent_count)
  );

  prbs_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .drain_en      (drain_en),
    .link          (link.receiver),
    .locked        (locked),
    .words_checked (words_checked),
    .errors        (errors)
  );

endmodule

/* tb_prbs.sv */
// --------------------------------------
// PRBS link test testbench
// Directed runs on prbs_top: clean, errors, back-pressure, restart
// --------------------------------------
`timescale 1ns/1ps
`include "prbs_config.svh"

module tb_prbs import prbs_pkg::*; ();

  localparam int clk_period     = 10;
  localparam int reset_cycles   = 16;
  // Random run lengths fall between these bounds
  localparam int run_min        = 12;
  localparam int run_max        = 60;
  // Cycles without counter movement that mark a drained link
  localparam int idle_cycles    = 8;
  localparam int drain_limit    = 64;
  localparam int inject_count   = 3;
  localparam int inject_gap_max = 13;
  localparam int bp_hold        = 24;
  localparam int restarts       = 2;

  // --------------------------------------
  // Cycle budget per test
  // --------------------------------------
  localparam int t_reset   = reset_cycles + 2;
  localparam int t_clean   = 4 + run_max + 4 + drain_limit;
  localparam int t_inject  = 4 + 6 + inject_count * inject_gap_max + 10 + 4 + drain_limit;
  localparam int t_bp      = 4 + bp_hold + 6 + drain_limit;
  localparam int t_restart = restarts * (4 + run_max + 6 + drain_limit);
  localparam int timeout_cycles = t_reset + t_clean + t_inject + t_bp + t_restart + 32;

  logic      clk;
  logic      rst;
  logic      start;
  logic      stop;
  logic      inject_error;
  logic      drain_en;
  stat_cnt_t sent_count;
  stat_cnt_t words_checked;
  stat_cnt_t errors;
  logic      locked;

  int          mismatch_count = 0;
  int          other_fail_count = 0;
  // Every start sends one sof word that the checker does not count
  int          start_count = 0;
  logic [31:0] rng_state = 32'd50051;

  prbs_top DUT (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .stop          (stop),
    .inject_error  (inject_error),
    .drain_en      (drain_en),
    .sent_count    (sent_count),
    .words_checked (words_checked),
    .errors        (errors),
    .locked        (locked)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------
  // Helpers
  // --------------------------------------

  // LCG step whose upper bits give the value
  function automatic int unsigned next_rand(input int unsigned bound);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return (rng_state >> 8) % bound;
  endfunction

  task automatic compare_count(input stat_cnt_t actual, input stat_cnt_t expected,
                               input string what);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic compare_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    start_count++;
  endtask

  task automatic pulse_stop();
    @(posedge clk);
    stop <= 1'b1;
    @(posedge clk);
    stop <= 1'b0;
  endtask

  // Returns at a falling edge once both counters have stopped moving
  task automatic wait_idle(input string what);
    stat_cnt_t last_sent;
    stat_cnt_t last_checked;
    int        stable;
    int        waited;
    stable = 0;
    waited = 0;
    @(negedge clk);
    last_sent    = sent_count;
    last_checked = words_checked;
    while (stable < idle_cycles && waited < drain_limit) begin
      @(negedge clk);
      waited++;
      if (sent_count == last_sent && words_checked == last_checked) begin
        stable++;
      end else begin
        stable       = 0;
        last_sent    = sent_count;
        last_checked = words_checked;
      end
    end
    if (stable < idle_cycles) begin
      other_fail_count++;
      $display("%s: the link did not drain within %0d cycles", what, drain_limit);
    end
  endtask

  // All words but one sof per start must have been checked
  task automatic check_accounting(input string what);
    compare_count(words_checked, sent_count - stat_cnt_t'(start_count), what);
  endtask

  // --------------------------------------
  // Tests
  // --------------------------------------

  task automatic test_reset_state();
    @(negedge clk);
    compare_count(sent_count, '0, "reset sent_count");
    compare_count(words_checked, '0, "reset words_checked");
    compare_count(errors, '0, "reset errors");
    compare_flag(locked, 1'b0, "reset locked");
  endtask

  task automatic test_clean_run();
    @(posedge clk);
    drain_en <= 1'b1;
    pulse_start();
    wait_cycles(run_min + next_rand(run_max - run_min));
    pulse_stop();
    wait_idle("clean run");
    compare_flag(locked, 1'b1, "clean run locked");
    compare_count(errors, '0, "clean run errors");
    check_accounting("clean run words_checked");
  endtask

  task automatic test_error_injection();
    stat_cnt_t errors_before;
    errors_before = errors;
    pulse_start();
    // Let the credit loop reach steady flow first
    wait_cycles(6);
    for (int i = 0; i < inject_count; i++) begin
      @(posedge clk);
      inject_error <= 1'b1;
      @(posedge clk);
      inject_error <= 1'b0;
      wait_cycles(4 + next_rand(8));
    end
    wait_cycles(10);
    pulse_stop();
    wait_idle("error injection");
    compare_count(errors, errors_before + stat_cnt_t'(inject_count), "injected errors");
    check_accounting("error injection words_checked");
  endtask

  task automatic test_back_pressure();
    stat_cnt_t sent_before;
    stat_cnt_t checked_before;
    stat_cnt_t errors_before;
    sent_before    = sent_count;
    checked_before = words_checked;
    errors_before  = errors;
    @(posedge clk);
    drain_en <= 1'b0;
    pulse_start();
    wait_cycles(bp_hold);
    @(negedge clk);
    // Only the initial credits can be spent while the queue is held
    compare_count(sent_count, sent_before + stat_cnt_t'(`LINK_CREDITS), "held sent_count");
    compare_count(words_checked, checked_before, "held words_checked");
    @(posedge clk);
    drain_en <= 1'b1;
    pulse_stop();
    wait_idle("back-pressure");
    compare_count(errors, errors_before, "back-pressure errors");
    check_accounting("back-pressure words_checked");
  endtask

  task automatic test_restart();
    stat_cnt_t errors_before;
    int        len;
    errors_before = errors;
    for (int r = 0; r < restarts; r++) begin
      pulse_start();
      len = run_min + next_rand(run_max - run_min);
      // Drain drops out for about one cycle in four
      repeat (len) begin
        @(posedge clk);
        drain_en <= (next_rand(4) != 0);
      end
      @(posedge clk);
      drain_en <= 1'b1;
      pulse_stop();
      wait_idle("restart");
      compare_flag(locked, 1'b1, "restart locked");
      compare_count(errors, errors_before, "restart errors");
      check_accounting("restart words_checked");
    end
  endtask

  // --------------------------------------
  // Sequence and watchdog
  // --------------------------------------

  initial begin
    rst          = 1'b1;
    start        = 1'b0;
    stop         = 1'b0;
    inject_error = 1'b0;
    drain_en     = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_clean_run();
    test_error_injection();
    test_back_pressure();
    test_restart();
    $display("Summary: %0d mismatches, %0d other failures", mismatch_count, other_fail_count);
    if (mismatch_count == 0 && other_fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* prbs.f */
+incdir+.
prbs_pkg.sv
prbs_link_if.sv
lfsr.sv
prbs_generator.sv
prbs_checker.sv
prbs_top.sv
tb_prbs.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PRBS link testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_prbs -f prbs.f \
  && ./obj_dir/Vtb_prbs > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0
